// File: jtdsp16_filt.f
+incdir+verification
src/jtdsp16_dsp_pkg.sv
src/jtdsp16_ctl_pkg.sv
src/jtdsp16_coef_aau.sv
src/jtdsp16_smp_aau.sv
src/jtdsp16_dau.sv
src/jtdsp16_ctrl.sv
src/jtdsp16_filt.sv
verification/jtdsp16_clk_gen.sv
verification/jtdsp16_filt_tb.sv

// File: Makefile
# Verilator build, run and lint for the FIR filter engine

VERILATOR  ?= verilator
TOP        ?= jtdsp16_filt_tb
RTL_TOP    ?= jtdsp16_filt
FILELIST   ?= jtdsp16_filt.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall

RTL_SRCS := src/jtdsp16_dsp_pkg.sv src/jtdsp16_ctl_pkg.sv src/jtdsp16_coef_aau.sv \
            src/jtdsp16_smp_aau.sv src/jtdsp16_dau.sv src/jtdsp16_ctrl.sv src/jtdsp16_filt.sv
TB_SRCS  := verification/jtdsp16_clk_gen.sv verification/jtdsp16_filt_tb.sv \
            verification/jtdsp16_filt_tests.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(RTL_SRCS) $(TB_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/jtdsp16_filt_tests.svh
//********************
// Directed tests of the FIR filter engine
// Single tap, random FIR, saturation,
// clear, back-pressure and cen gating
//********************
`ifndef JTDSP16_FILT_TESTS_SVH
`define JTDSP16_FILT_TESTS_SVH

task automatic single_tap();
    jtdsp16_dsp_pkg::sample_t x;
    send_cmd(jtdsp16_ctl_pkg::OP_SET_TAPS, 16'd1);
    wait_idle(200);
    check_credits(credit_pulses, cmds_sent, "set taps");
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'd16384);    // 0.5 in Q15
    wait_idle(200);
    check_credits(credit_pulses, cmds_sent, "load coefficient");
    for (int i = 0; i < 8; i++) begin
        x = jtdsp16_dsp_pkg::sample_t'($urandom);
        send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, x);
        wait_idle(200);
        check_out(last_out, x >>> 1, "single tap output");
        check_credits(credit_pulses, cmds_sent, "single tap sample");
    end
endtask

task automatic random_fir();
    send_cmd(jtdsp16_ctl_pkg::OP_CLEAR, 16'd0);
    send_cmd(jtdsp16_ctl_pkg::OP_SET_TAPS, 16'd7);
    for (int k = 0; k < $size(fir_coef); k++) begin
        fir_coef[k] = jtdsp16_dsp_pkg::coef_t'($urandom) >>> 2;  // Most sums stay in range
        send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, fir_coef[k]);
    end
    // 30 writes wrap the 16 entry history
    for (int i = 0; i < $size(fir_smp); i++) begin
        fir_smp[i] = jtdsp16_dsp_pkg::sample_t'($urandom);
        send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, fir_smp[i]);
    end
    wait_idle(1000);
    check_credits(credit_pulses, cmds_sent, "random FIR");
endtask

task automatic saturation_clamp();
    jtdsp16_dsp_pkg::sample_t lim;
    send_cmd(jtdsp16_ctl_pkg::OP_SET_TAPS, 16'd4);
    for (int k = 0; k < 4; k++) begin
        send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'h7fff);
    end
    for (int g = 0; g < 3; g++) begin
        lim = (g == 1) ? jtdsp16_dsp_pkg::sample_t'(-32768)
                       : jtdsp16_dsp_pkg::sample_t'(32767);
        for (int i = 0; i < 4; i++) begin
            send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, lim);
        end
        wait_idle(400);
        check_out(last_out, lim, "clamped output");   // Four equal taps overflow Q15
    end
    check_credits(credit_pulses, cmds_sent, "saturation");
endtask

task automatic clear_history();
    jtdsp16_dsp_pkg::sample_t x;
    send_cmd(jtdsp16_ctl_pkg::OP_SET_TAPS, 16'd4);
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'd8192);     // 0.25
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'hd120);
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'd12000);
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'd3000);
    for (int i = 0; i < 5; i++) begin
        send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, 16'($urandom));
    end
    send_cmd(jtdsp16_ctl_pkg::OP_CLEAR, 16'd0);
    wait_idle(400);
    // Only tap 0 sees data right after a clear
    x = jtdsp16_dsp_pkg::sample_t'($urandom);
    send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, x);
    wait_idle(200);
    check_out(last_out, x >>> 2, "first output after clear");
    for (int i = 0; i < 3; i++) begin
        send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, 16'($urandom));
    end
    wait_idle(400);
    check_credits(credit_pulses, cmds_sent, "clear");
endtask

task automatic back_pressure();
    int base;
    send_cmd(jtdsp16_ctl_pkg::OP_SET_TAPS, 16'd3);
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'd9000);
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'hc000);
    send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, 16'd20000);
    wait_idle(200);
    hold_credits = 1'b1;
    base = results_seen;
    // Two emitted, one parked in the DAU, two queued
    for (int i = 0; i < 5; i++) begin
        send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, 16'($urandom));
    end
    repeat (100) @(posedge clk);
    #1;
    if (results_seen - base > int'(jtdsp16_ctl_pkg::OUT_CREDITS)) begin
        other_errors++;
        $display("%0t ns: %0d results sent with result credits withheld",
                 $time, results_seen - base);
    end
    hold_credits = 1'b0;
    wait_idle(600);
    check_credits(credit_pulses, cmds_sent, "back-pressure");
endtask

task automatic cen_gating();
    cen_random = 1'b1;
    send_cmd(jtdsp16_ctl_pkg::OP_CLEAR, 16'd0);
    send_cmd(jtdsp16_ctl_pkg::OP_SET_TAPS, 16'd7);
    for (int k = 0; k < $size(fir_coef); k++) begin
        send_cmd(jtdsp16_ctl_pkg::OP_LOAD_COEF, fir_coef[k]);
    end
    for (int i = 0; i < $size(fir_smp); i++) begin
        send_cmd(jtdsp16_ctl_pkg::OP_SAMPLE, fir_smp[i]);
    end
    wait_idle(2000);
    cen_random = 1'b0;
    check_credits(credit_pulses, cmds_sent, "cen gating");
endtask

`endif

// File: verification/jtdsp16_filt_tb.sv
//********************
// FIR filter engine testbench
// DUT instance, host and reference models,
// compare tasks, timeout and summary
//********************
`timescale 1ns/100ps
`default_nettype none

module jtdsp16_filt_tb;

logic                        clk;
logic                        cen;
logic                        rst_n;
logic                        cmd_valid;
jtdsp16_ctl_pkg::op_e        cmd_op;
logic [15:0]                 cmd_data;
logic                        cmd_credit;
logic                        out_valid;
jtdsp16_dsp_pkg::sample_t    out_data;
logic                        out_credit;

// Host side bookkeeping
int  host_credits;
int  dut_out_credits;   // Result credits the DUT should hold
int  owed_credits;      // Results not yet answered with out_credit
bit  hold_credits;
bit  cen_random;
int  cmds_sent;
int  credit_pulses;
int  results_seen;
int  cycles;
int  value_errors;
int  other_errors;
jtdsp16_dsp_pkg::sample_t last_out;
jtdsp16_dsp_pkg::sample_t exp_q [$];

// Reference model state
jtdsp16_dsp_pkg::coef_t   m_coef [jtdsp16_dsp_pkg::MAX_TAPS];
jtdsp16_dsp_pkg::sample_t m_hist [jtdsp16_dsp_pkg::MAX_TAPS];
int  m_taps;
int  m_coef_ptr;
int  m_head;

// Test 2 stimulus, replayed under cen gating
jtdsp16_dsp_pkg::coef_t   fir_coef [7];
jtdsp16_dsp_pkg::sample_t fir_smp  [30];

jtdsp16_clk_gen u_clk_gen(
    .clk        ( clk        )
);

jtdsp16_filt u_jtdsp16_filt(
    .clk        ( clk        ),
    .cen        ( cen        ),
    .rst_n      ( rst_n      ),
    .cmd_valid  ( cmd_valid  ),
    .cmd_op     ( cmd_op     ),
    .cmd_data   ( cmd_data   ),
    .cmd_credit ( cmd_credit ),
    .out_valid  ( out_valid  ),
    .out_data   ( out_data   ),
    .out_credit ( out_credit )
);

function automatic jtdsp16_dsp_pkg::sample_t fir_output();
    longint acc;
    int     idx;
    acc = 0;
    for (int k = 0; k < m_taps; k++) begin
        idx = (m_head - 1 - k + 2 * jtdsp16_dsp_pkg::MAX_TAPS) % jtdsp16_dsp_pkg::MAX_TAPS;
        acc += longint'(m_coef[k]) * longint'(m_hist[idx]);
    end
    acc = acc >>> jtdsp16_dsp_pkg::Q_SHIFT;
    if (acc > 32767) begin
        return jtdsp16_dsp_pkg::sample_t'(32767);
    end else if (acc < -32768) begin
        return jtdsp16_dsp_pkg::sample_t'(-32768);
    end
    return jtdsp16_dsp_pkg::sample_t'(acc);
endfunction

task automatic model_apply(input jtdsp16_ctl_pkg::op_e op, input logic [15:0] data);
    case (op)
        jtdsp16_ctl_pkg::OP_SET_TAPS: begin
            if (data == 16'd0) begin
                m_taps = 1;
            end else if (int'(data) > jtdsp16_dsp_pkg::MAX_TAPS) begin
                m_taps = jtdsp16_dsp_pkg::MAX_TAPS;
            end else begin
                m_taps = int'(data);
            end
            m_coef_ptr = 0;
        end
        jtdsp16_ctl_pkg::OP_LOAD_COEF: begin
            m_coef[m_coef_ptr] = jtdsp16_dsp_pkg::coef_t'(data);
            m_coef_ptr = (m_coef_ptr + 1) % jtdsp16_dsp_pkg::MAX_TAPS;
        end
        jtdsp16_ctl_pkg::OP_SAMPLE: begin
            m_hist[m_head] = jtdsp16_dsp_pkg::sample_t'(data);
            m_head = (m_head + 1) % jtdsp16_dsp_pkg::MAX_TAPS;
            exp_q.push_back(fir_output());
        end
        default: begin
            for (int i = 0; i < jtdsp16_dsp_pkg::MAX_TAPS; i++) begin
                m_hist[i] = '0;
            end
        end
    endcase
endtask

// Called 1 ns after a rising edge
task automatic send_cmd(input jtdsp16_ctl_pkg::op_e op, input logic [15:0] data);
    while (host_credits == 0) begin
        @(posedge clk);
        #1;
    end
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_data  = data;
    do begin
        @(posedge clk);
    end while (!cen);       // Taken only on an enabled edge
    host_credits--;
    cmds_sent++;
    model_apply(op, data);
    #1;
    cmd_valid = 1'b0;
endtask

task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || owed_credits != 0 ||
            host_credits < int'(jtdsp16_ctl_pkg::CMD_CREDITS)) && n < limit) begin
        @(posedge clk);
        #1;
        n++;
    end
    if (exp_q.size() != 0 || host_credits < int'(jtdsp16_ctl_pkg::CMD_CREDITS)) begin
        other_errors++;
        $display("%0t ns: %0d results missing and %0d command credits not returned",
                 $time, exp_q.size(), int'(jtdsp16_ctl_pkg::CMD_CREDITS) - host_credits);
        $display("%0t ns: gave up waiting after %0d cycles", $time, n);
    end
endtask

task automatic check_out(input jtdsp16_dsp_pkg::sample_t got,
                         input jtdsp16_dsp_pkg::sample_t exp, input string what);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_credits(input int got, input int exp, input string what);
    if (got != exp) begin
        value_errors++;
        $display("FAILED %0t ns: %s: %0d cmd_credit pulses for %0d commands",
                 $time, what, got, exp);
    end
endtask

task automatic finish_run();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
endtask

// Host side of both ports
always @(posedge clk) begin
    if (rst_n) begin
        if (cen && cmd_credit) begin
            credit_pulses++;
            host_credits++;
        end
        if (cen && out_credit) begin
            owed_credits--;
            dut_out_credits++;
        end
        if (cen && out_valid) begin
            if (dut_out_credits == 0) begin
                other_errors++;
                $display("%0t ns: result sent while the DUT held no result credit", $time);
            end else begin
                dut_out_credits--;
            end
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("%0t ns: result arrived with no sample command pending", $time);
            end else begin
                check_out(out_data, exp_q.pop_front(), "filter output");
            end
            last_out = out_data;
            results_seen++;
            owed_credits++;
        end
        #1;
        out_credit = !hold_credits && owed_credits > 0;
    end
end

always @(posedge clk) begin
    #1;
    if (cen_random) begin
        cen = ($urandom % 4) != 0;
    end else begin
        cen = 1'b1;
    end
end

// Limit grows with the commands sent
always @(posedge clk) begin
    cycles++;
    if (cycles > 60 * cmds_sent + 200) begin
        other_errors++;
        $display("Timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
        finish_run();
    end
end

initial begin
    void'($urandom(32'hb74));
    cen             = 1'b1;
    rst_n           = 1'b0;
    cmd_valid       = 1'b0;
    cmd_op          = jtdsp16_ctl_pkg::OP_SET_TAPS;
    cmd_data        = '0;
    out_credit      = 1'b0;
    host_credits    = int'(jtdsp16_ctl_pkg::CMD_CREDITS);
    dut_out_credits = int'(jtdsp16_ctl_pkg::OUT_CREDITS);
    m_taps          = 1;
    m_coef_ptr      = 0;
    m_head          = 0;
    for (int i = 0; i < jtdsp16_dsp_pkg::MAX_TAPS; i++) begin
        m_coef[i] = '0;
        m_hist[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    single_tap();
    random_fir();
    saturation_clamp();
    clear_history();
    back_pressure();
    cen_gating();
    finish_run();
end

`include "jtdsp16_filt_tests.svh"

endmodule

`default_nettype wire

// File: verification/jtdsp16_clk_gen.sv
//********************
// Testbench clock source
// Free running, 4 ns period
//********************
`timescale 1ns/100ps
`default_nettype none

module jtdsp16_clk_gen(
    output logic clk
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // Half of 4 ns
end

endmodule

`default_nettype wire

// File: src/jtdsp16_filt.sv
//********************
// FIR filter engine top level
// Controller, coefficient and sample
// AAUs and the DAU
//********************
`timescale 1ns/100ps
`default_nettype none

module jtdsp16_filt(
    input  logic                               clk,
    input  logic                               cen,
    input  logic                               rst_n,
    // Command port
    input  logic                               cmd_valid,
    input  jtdsp16_ctl_pkg::op_e               cmd_op,
    input  logic [jtdsp16_dsp_pkg::DATA_W-1:0] cmd_data,
    output logic                               cmd_credit,
    // Result port
    output logic                               out_valid,
    output jtdsp16_dsp_pkg::sample_t           out_data,
    input  logic                               out_credit
);

logic                     coef_we, coef_ptr_rst, coef_vld;
jtdsp16_dsp_pkg::coef_t   coef_wdata, coef_rd;
logic                     smp_we, smp_vld, clr_start, clr_done;
jtdsp16_dsp_pkg::sample_t smp_wdata, smp_rd;
logic                     tap_start, acc_clr, emit, mac_done;
jtdsp16_dsp_pkg::tap_t    num_taps;

jtdsp16_ctrl u_ctrl(
    .clk            ( clk           ),
    .cen            ( cen           ),
    .rst_n          ( rst_n         ),
    .cmd_valid      ( cmd_valid     ),
    .cmd_op         ( cmd_op        ),
    .cmd_data       ( cmd_data      ),
    .cmd_credit     ( cmd_credit    ),
    .out_credit     ( out_credit    ),
    .coef_we        ( coef_we       ),
    .coef_wdata     ( coef_wdata    ),
    .coef_ptr_rst   ( coef_ptr_rst  ),
    .smp_we         ( smp_we        ),
    .smp_wdata      ( smp_wdata     ),
    .clr_start      ( clr_start     ),
    .clr_done       ( clr_done      ),
    .tap_start      ( tap_start     ),
    .num_taps       ( num_taps      ),
    .acc_clr        ( acc_clr       ),
    .emit           ( emit          ),
    .mac_done       ( mac_done      )
);

// ROM AAU counterpart
jtdsp16_coef_aau u_coef_aau(
    .clk            ( clk           ),
    .cen            ( cen           ),
    .rst_n          ( rst_n         ),
    .coef_we        ( coef_we       ),
    .coef_wdata     ( coef_wdata    ),
    .coef_ptr_rst   ( coef_ptr_rst  ),
    .tap_start      ( tap_start     ),
    .num_taps       ( num_taps      ),
    .coef_rd        ( coef_rd       ),
    .coef_vld       ( coef_vld      )
);

// RAM AAU counterpart
jtdsp16_smp_aau u_smp_aau(
    .clk            ( clk           ),
    .cen            ( cen           ),
    .rst_n          ( rst_n         ),
    .smp_we         ( smp_we        ),
    .smp_wdata      ( smp_wdata     ),
    .clr_start      ( clr_start     ),
    .clr_done       ( clr_done      ),
    .tap_start      ( tap_start     ),
    .num_taps       ( num_taps      ),
    .smp_rd         ( smp_rd        ),
    .smp_vld        ( smp_vld       )
);

jtdsp16_dau u_dau(
    .clk            ( clk           ),
    .cen            ( cen           ),
    .rst_n          ( rst_n         ),
    .coef_rd        ( coef_rd       ),
    .coef_vld       ( coef_vld      ),
    .smp_rd         ( smp_rd        ),
    .smp_vld        ( smp_vld       ),
    .acc_clr        ( acc_clr       ),
    .emit           ( emit          ),
    .mac_done       ( mac_done      ),
    .out_valid      ( out_valid     ),
    .out_data       ( out_data      )
);

endmodule

`default_nettype wire

// File: src/jtdsp16_ctrl.sv
//********************
// Filter controller
// Two-entry command queue, decoder FSM,
// command and result credit counters
//********************
`timescale 1ns/100ps
`default_nettype none

module jtdsp16_ctrl(
    input  logic                               clk,
    input  logic                               cen,
    input  logic                               rst_n,
    // Command port
    input  logic                               cmd_valid,
    input  jtdsp16_ctl_pkg::op_e               cmd_op,
    input  logic [jtdsp16_dsp_pkg::DATA_W-1:0] cmd_data,
    output logic                               cmd_credit,
    input  logic                               out_credit,
    // Coefficient AAU
    output logic                               coef_we,
    output jtdsp16_dsp_pkg::coef_t             coef_wdata,
    output logic                               coef_ptr_rst,
    // Sample AAU
    output logic                               smp_we,
    output jtdsp16_dsp_pkg::sample_t           smp_wdata,
    output logic                               clr_start,
    input  logic                               clr_done,
    // Both AAUs
    output logic                               tap_start,
    output jtdsp16_dsp_pkg::tap_t              num_taps,
    // DAU
    output logic                               acc_clr,
    output logic                               emit,
    input  logic                               mac_done
);

jtdsp16_ctl_pkg::op_e                    q_op   [jtdsp16_ctl_pkg::CMD_CREDITS];
logic [jtdsp16_dsp_pkg::DATA_W-1:0]      q_data [jtdsp16_ctl_pkg::CMD_CREDITS];
logic                                    q_wr;
logic                                    q_rd;
logic [jtdsp16_ctl_pkg::CRD_W-1:0]       q_cnt;
logic                                    q_pop;
logic [jtdsp16_ctl_pkg::CRD_W-1:0]       out_cnt;  // Result credits held
logic                                    emit_ok;
logic [jtdsp16_dsp_pkg::DATA_W-1:0]      wdata;
jtdsp16_ctl_pkg::ctrl_state_e            state;

function automatic jtdsp16_dsp_pkg::tap_t clamp_taps(
    input logic [jtdsp16_dsp_pkg::DATA_W-1:0] n
);
    if (n == '0) begin
        return jtdsp16_dsp_pkg::tap_t'(1);
    end else if (n > jtdsp16_dsp_pkg::MAX_TAPS) begin
        return jtdsp16_dsp_pkg::tap_t'(jtdsp16_dsp_pkg::MAX_TAPS);
    end
    return n[jtdsp16_dsp_pkg::TAP_W-1:0];
endfunction

assign q_pop   = state == jtdsp16_ctl_pkg::IDLE && q_cnt != '0;
assign emit_ok = state == jtdsp16_ctl_pkg::EMIT && out_cnt != '0;

assign coef_wdata = jtdsp16_dsp_pkg::coef_t'(wdata);
assign smp_wdata  = jtdsp16_dsp_pkg::sample_t'(wdata);

always_ff @(posedge clk) begin
    if (cen && cmd_valid) begin
        q_op[q_wr]   <= cmd_op;
        q_data[q_wr] <= cmd_data;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        q_wr    <= 1'b0;
        q_rd    <= 1'b0;
        q_cnt   <= '0;
        out_cnt <= jtdsp16_ctl_pkg::OUT_CREDITS;
    end else if (cen) begin
        q_wr <= q_wr ^ cmd_valid;
        q_rd <= q_rd ^ q_pop;
        case ({cmd_valid, q_pop})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: ;
        endcase
        case ({out_credit, emit_ok})
            2'b10:   out_cnt <= out_cnt + 1'b1;
            2'b01:   out_cnt <= out_cnt - 1'b1;
            default: ;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state        <= jtdsp16_ctl_pkg::IDLE;
        num_taps     <= jtdsp16_dsp_pkg::tap_t'(1);
        cmd_credit   <= 1'b0;
        coef_we      <= 1'b0;
        coef_ptr_rst <= 1'b0;
        smp_we       <= 1'b0;
        clr_start    <= 1'b0;
        tap_start    <= 1'b0;
        acc_clr      <= 1'b0;
        emit         <= 1'b0;
    end else if (cen) begin
        cmd_credit   <= q_pop;      // Slot freed
        coef_we      <= 1'b0;
        coef_ptr_rst <= 1'b0;
        smp_we       <= 1'b0;
        clr_start    <= 1'b0;
        tap_start    <= 1'b0;
        acc_clr      <= 1'b0;
        emit         <= 1'b0;
        case (state)
            jtdsp16_ctl_pkg::IDLE: if (q_pop) begin
                wdata <= q_data[q_rd];
                case (q_op[q_rd])
                    jtdsp16_ctl_pkg::OP_SET_TAPS: begin
                        num_taps     <= clamp_taps(q_data[q_rd]);
                        coef_ptr_rst <= 1'b1;
                    end
                    jtdsp16_ctl_pkg::OP_LOAD_COEF: coef_we <= 1'b1;
                    jtdsp16_ctl_pkg::OP_SAMPLE: begin
                        smp_we <= 1'b1;
                        state  <= jtdsp16_ctl_pkg::RUNNING;
                    end
                    default: begin
                        clr_start <= 1'b1;
                        state     <= jtdsp16_ctl_pkg::CLEARING;
                    end
                endcase
            end
            jtdsp16_ctl_pkg::CLEARING: if (clr_done) begin
                state <= jtdsp16_ctl_pkg::IDLE;
            end
            // Head has moved, start the walk
            jtdsp16_ctl_pkg::RUNNING: begin
                tap_start <= 1'b1;
                acc_clr   <= 1'b1;
                state     <= jtdsp16_ctl_pkg::DRAIN;
            end
            jtdsp16_ctl_pkg::DRAIN: if (mac_done) begin
                state <= jtdsp16_ctl_pkg::EMIT;
            end
            jtdsp16_ctl_pkg::EMIT: if (emit_ok) begin   // Stalls here with no credit
                emit  <= 1'b1;
                state <= jtdsp16_ctl_pkg::IDLE;
            end
            default: state <= jtdsp16_ctl_pkg::IDLE;
        endcase
    end
end

// Host may only send while it holds a credit
a_no_q_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    cen && q_cnt == jtdsp16_ctl_pkg::CMD_CREDITS |-> !cmd_valid);

endmodule

`default_nettype wire

// File: src/jtdsp16_dau.sv
//********************
// Data arithmetic unit
// Two-stage MAC, Q15 scaling, saturation
// and the result register
//********************
`timescale 1ns/100ps
`default_nettype none

module jtdsp16_dau(
    input  logic                     clk,
    input  logic                     cen,
    input  logic                     rst_n,
    // Operand streams
    input  jtdsp16_dsp_pkg::coef_t   coef_rd,
    input  logic                     coef_vld,
    input  jtdsp16_dsp_pkg::sample_t smp_rd,
    input  logic                     smp_vld,
    // Control
    input  logic                     acc_clr,
    input  logic                     emit,
    output logic                     mac_done,
    // Result
    output logic                     out_valid,
    output jtdsp16_dsp_pkg::sample_t out_data
);

logic signed [2*jtdsp16_dsp_pkg::DATA_W-1:0] prod;
logic                                        p_vld;     // Product stage full
logic                                        a_vld;     // Accumulate done
jtdsp16_dsp_pkg::acc_t                       acc;
jtdsp16_dsp_pkg::acc_t                       scaled;
jtdsp16_dsp_pkg::sample_t                    sat_val;
jtdsp16_dsp_pkg::sample_t                    hold;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        p_vld     <= 1'b0;
        a_vld     <= 1'b0;
        out_valid <= 1'b0;
    end else if (cen) begin
        p_vld     <= coef_vld;
        a_vld     <= p_vld;
        out_valid <= emit;
    end
end

always_ff @(posedge clk) begin
    if (cen) begin
        if (coef_vld) begin
            prod <= coef_rd * smp_rd;
        end
        if (acc_clr) begin
            acc <= '0;
        end else if (p_vld) begin
            acc <= acc + jtdsp16_dsp_pkg::acc_t'(prod);
        end
        if (mac_done) begin
            hold <= sat_val;
        end
        if (emit) begin
            out_data <= hold;
        end
    end
end

// Sum is final once the adder drains
assign mac_done = a_vld && !p_vld;

always_comb begin
    scaled = acc >>> jtdsp16_dsp_pkg::Q_SHIFT;
    // Fits when all bits above the Q15 sign agree
    if (scaled[jtdsp16_dsp_pkg::ACC_W-1:jtdsp16_dsp_pkg::DATA_W-1] == '0 ||
        scaled[jtdsp16_dsp_pkg::ACC_W-1:jtdsp16_dsp_pkg::DATA_W-1] == '1) begin
        sat_val = scaled[jtdsp16_dsp_pkg::DATA_W-1:0];
    end else if (scaled[jtdsp16_dsp_pkg::ACC_W-1]) begin
        sat_val = {1'b1, {(jtdsp16_dsp_pkg::DATA_W-1){1'b0}}};
    end else begin
        sat_val = {1'b0, {(jtdsp16_dsp_pkg::DATA_W-1){1'b1}}};
    end
end

// Both address units walk in lockstep
a_vld_lockstep: assert property (@(posedge clk) disable iff (!rst_n)
    cen |-> coef_vld == smp_vld);

endmodule

`default_nettype wire

// File: src/jtdsp16_smp_aau.sv
//********************
// Sample address unit
// Circular history with modulo head,
// backwards tap reader and clear sweep
//********************
`timescale 1ns/100ps
`default_nettype none

module jtdsp16_smp_aau(
    input  logic                     clk,
    input  logic                     cen,
    input  logic                     rst_n,
    // Sample write
    input  logic                     smp_we,
    input  jtdsp16_dsp_pkg::sample_t smp_wdata,
    // History clear
    input  logic                     clr_start,
    output logic                     clr_done,
    // Tap walk
    input  logic                     tap_start,
    input  jtdsp16_dsp_pkg::tap_t    num_taps,
    output jtdsp16_dsp_pkg::sample_t smp_rd,
    output logic                     smp_vld
);

jtdsp16_dsp_pkg::sample_t           smp_mem [jtdsp16_dsp_pkg::MAX_TAPS];
logic [jtdsp16_dsp_pkg::ADDR_W-1:0] head;       // Next slot to write
logic [jtdsp16_dsp_pkg::ADDR_W-1:0] rd_ptr;
logic [jtdsp16_dsp_pkg::ADDR_W-1:0] clr_idx;
logic                               clr_busy;
jtdsp16_dsp_pkg::tap_t              left;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        head <= '0;
        for (int i = 0; i < jtdsp16_dsp_pkg::MAX_TAPS; i++) begin
            smp_mem[i] <= '0;
        end
    end else if (cen) begin
        if (clr_busy) begin
            smp_mem[clr_idx] <= '0;
        end else if (smp_we) begin
            smp_mem[head] <= smp_wdata;
            head          <= head + 1'b1;
        end
    end
end

// Zero sweep, one entry per cycle
always_ff @(posedge clk) begin
    if (!rst_n) begin
        clr_busy <= 1'b0;
        clr_idx  <= '0;
        clr_done <= 1'b0;
    end else if (cen) begin
        clr_done <= 1'b0;
        if (clr_start) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
        end else if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (&clr_idx) begin     // Last entry
                clr_busy <= 1'b0;
                clr_done <= 1'b1;
            end
        end
    end
end

// Newest sample first, then back in time
always_ff @(posedge clk) begin
    if (!rst_n) begin
        rd_ptr <= '0;
        left   <= '0;
    end else if (cen) begin
        if (tap_start) begin
            rd_ptr <= head - 1'b1;
            left   <= num_taps;
        end else if (smp_vld) begin
            rd_ptr <= rd_ptr - 1'b1;
            left   <= left - 1'b1;
        end
    end
end

assign smp_rd  = smp_mem[rd_ptr];
assign smp_vld = left != '0;

a_clr_tap_excl: assert property (@(posedge clk) disable iff (!rst_n)
    cen |-> !(clr_start && tap_start));

endmodule

`default_nettype wire

// File: src/jtdsp16_coef_aau.sv
//********************
// Coefficient address unit
// Programmable coefficient memory, load
// pointer and the tap read sequencer
//********************
`timescale 1ns/100ps
`default_nettype none

module jtdsp16_coef_aau(
    input  logic                   clk,
    input  logic                   cen,
    input  logic                   rst_n,
    // Coefficient load
    input  logic                   coef_we,
    input  jtdsp16_dsp_pkg::coef_t coef_wdata,
    input  logic                   coef_ptr_rst,
    // Tap walk
    input  logic                   tap_start,
    input  jtdsp16_dsp_pkg::tap_t  num_taps,
    output jtdsp16_dsp_pkg::coef_t coef_rd,
    output logic                   coef_vld
);

jtdsp16_dsp_pkg::coef_t             coef_mem [jtdsp16_dsp_pkg::MAX_TAPS];
logic [jtdsp16_dsp_pkg::ADDR_W-1:0] wr_ptr;
logic [jtdsp16_dsp_pkg::ADDR_W-1:0] rd_ptr;
jtdsp16_dsp_pkg::tap_t              left;       // Taps still to present

always_ff @(posedge clk) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        for (int i = 0; i < jtdsp16_dsp_pkg::MAX_TAPS; i++) begin
            coef_mem[i] <= '0;
        end
    end else if (cen) begin
        if (coef_ptr_rst) begin
            wr_ptr <= '0;
        end else if (coef_we) begin
            coef_mem[wr_ptr] <= coef_wdata;
            wr_ptr           <= wr_ptr + 1'b1;  // Wraps at MAX_TAPS
        end
    end
end

// Address 0 shows up the cycle after tap_start
always_ff @(posedge clk) begin
    if (!rst_n) begin
        rd_ptr <= '0;
        left   <= '0;
    end else if (cen) begin
        if (tap_start) begin
            rd_ptr <= '0;
            left   <= num_taps;
        end else if (coef_vld) begin
            rd_ptr <= rd_ptr + 1'b1;
            left   <= left - 1'b1;
        end
    end
end

assign coef_rd  = coef_mem[rd_ptr];
assign coef_vld = left != '0;

// Loads are only issued between samples
a_no_load_in_walk: assert property (@(posedge clk) disable iff (!rst_n)
    cen |-> !(coef_we && coef_vld));

endmodule

`default_nettype wire

// File: src/jtdsp16_ctl_pkg.sv
//********************
// Command opcodes, controller states
// and the credit counts of both ports
//********************
`default_nettype none

package jtdsp16_ctl_pkg;

    typedef enum logic [1:0] {
        OP_SET_TAPS,
        OP_LOAD_COEF,
        OP_SAMPLE,
        OP_CLEAR
    } op_e;

    typedef enum logic [2:0] {
        IDLE,
        CLEARING,
        RUNNING,    // Sample written, walk starts next
        DRAIN,
        EMIT
    } ctrl_state_e;

    localparam int               CRD_W       = 2;
    localparam logic [CRD_W-1:0] CMD_CREDITS = 2;   // Same as the queue depth
    localparam logic [CRD_W-1:0] OUT_CREDITS = 2;

endpackage

`default_nettype wire

// File: src/jtdsp16_dsp_pkg.sv
//********************
// Data path widths, tap limits and
// the fixed-point types shared by the
// address and data arithmetic units
//********************
`default_nettype none

package jtdsp16_dsp_pkg;

    localparam int DATA_W   = 16;   // Sample and coefficient width
    localparam int MAX_TAPS = 16;   // Depth of both memories
    localparam int ADDR_W   = 4;    // Memory index
    localparam int TAP_W    = 5;    // Holds 1..MAX_TAPS
    localparam int ACC_W    = 36;   // 4 guard bits over a 32-bit product
    localparam int Q_SHIFT  = 15;   // Back to Q15

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [DATA_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic        [TAP_W-1:0]  tap_t;

endpackage

`default_nettype wire
